// ==== common/ad9361_pkg.sv ====
// ad9361 receive side definitions
// sample format and channel layout of the transceiver pair

package ad9361_pkg;

  ////////////////////////////////////////
  // sample format
  ////////////////////////////////////////

  // one converter sample, two's complement
  localparam int sample_width = 12;

  typedef logic [sample_width-1:0] sample_t;

  ////////////////////////////////////////
  // channel layout
  ////////////////////////////////////////

  // two transceivers, two receive paths each
  localparam int num_channels = 4;

  // slot index within one group of channels
  typedef logic [$clog2(num_channels)-1:0] chan_idx_t;

endpackage

// ==== common/axis_pkg.sv ====
// stream side definitions
// packed beat layout and counter widths for the AXI-stream master

package axis_pkg;

  ////////////////////////////////////////
  // beat layout
  ////////////////////////////////////////

  localparam int axis_width = 128;

  // one sample per lane, zero extended
  localparam int lane_width = 16;

  typedef logic [axis_width-1:0] axis_data_t;

  ////////////////////////////////////////
  // status counters
  ////////////////////////////////////////

  // saturates, never wraps
  localparam int overrun_width = 16;

  typedef logic [overrun_width-1:0] overrun_cnt_t;

endpackage

// ==== logic/rx_deinterleave.sv ====
// receive deinterleaver
// turns the shared I/Q bus into four held channel outputs and a group strobe

`timescale 1ns/100ps

module rx_deinterleave (
  input  logic                m_axis_clk,
  input  logic                arst_n,
  input  logic                rx_valid,
  input  logic                rx_frame,
  input  ad9361_pkg::sample_t rx_i,
  input  ad9361_pkg::sample_t rx_q,
  output logic                group_valid,
  output ad9361_pkg::sample_t data_i0,
  output ad9361_pkg::sample_t data_q0,
  output ad9361_pkg::sample_t data_i1,
  output ad9361_pkg::sample_t data_q1,
  output ad9361_pkg::sample_t data_i2,
  output ad9361_pkg::sample_t data_q2,
  output ad9361_pkg::sample_t data_i3,
  output ad9361_pkg::sample_t data_q3
);

  import ad9361_pkg::*;

  typedef enum logic {
    st_idle,
    st_collect
  } state_t;

  localparam chan_idx_t last_slot = chan_idx_t'(num_channels - 1);

  state_t    state;
  chan_idx_t slot;

  // staged channels 0 to 2, held until slot 3 completes the group
  sample_t   stage_i [num_channels-1];
  sample_t   stage_q [num_channels-1];

  logic      word_start;
  logic      word_fill;
  logic      word_last;
  logic      stage_we;
  chan_idx_t wr_slot;

  ////////////////////////////////////////
  // word classification
  ////////////////////////////////////////

  // a frame marker always restarts at slot 0
  assign word_start = rx_valid & rx_frame;
  assign word_fill  = rx_valid & ~rx_frame & (state == st_collect);
  assign word_last  = word_fill & (slot == last_slot);
  assign stage_we   = word_start | (word_fill & ~word_last);
  assign wr_slot    = word_start ? '0 : slot;

  ////////////////////////////////////////
  // slot tracking
  ////////////////////////////////////////

  always_ff @(posedge m_axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= st_idle;
      slot        <= '0;
      group_valid <= 1'b0;
    end else begin
      group_valid <= word_last;
      if (word_start) begin
        state <= st_collect;
        slot  <= chan_idx_t'(1);
      end else if (word_last) begin
        state <= st_idle;
        slot  <= '0;
      end else if (word_fill) begin
        slot <= slot + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // sample storage
  ////////////////////////////////////////

  always_ff @(posedge m_axis_clk) begin
    for (int c = 0; c < num_channels - 1; c++) begin
      if (stage_we && wr_slot == chan_idx_t'(c)) begin
        stage_i[c] <= rx_i;
        stage_q[c] <= rx_q;
      end
    end
  end

  // publish all four channels at once
  always_ff @(posedge m_axis_clk) begin
    if (word_last) begin
      data_i0 <= stage_i[0];
      data_q0 <= stage_q[0];
      data_i1 <= stage_i[1];
      data_q1 <= stage_q[1];
      data_i2 <= stage_i[2];
      data_q2 <= stage_q[2];
      data_i3 <= rx_i;
      data_q3 <= rx_q;
    end
  end

  // a group needs one word per slot, so strobes can never be adjacent
  group_valid_spacing_a: assert property (
    @(posedge m_axis_clk) disable iff (!arst_n)
    group_valid |=> !group_valid
  );

endmodule

// ==== ad9361_dual_axis/ad9361_dual_axis.sv ====
// AD9361 group packer
// packs one channel group into a 128-bit AXI-stream beat with tlast bursts
// and counts groups that overwrite a beat still waiting for tready

`timescale 1ns/100ps

module ad9361_dual_axis #(
  parameter int burst_len = 512,
  parameter bit use_tlast = 1
) (
  input  logic                   m_axis_clk,
  input  logic                   arst_n,
  input  logic                   group_valid,
  input  ad9361_pkg::sample_t    data_i0,
  input  ad9361_pkg::sample_t    data_q0,
  input  ad9361_pkg::sample_t    data_i1,
  input  ad9361_pkg::sample_t    data_q1,
  input  ad9361_pkg::sample_t    data_i2,
  input  ad9361_pkg::sample_t    data_q2,
  input  ad9361_pkg::sample_t    data_i3,
  input  ad9361_pkg::sample_t    data_q3,
  input  logic                   tready,
  output logic                   tvalid,
  output logic                   tlast,
  output axis_pkg::axis_data_t   tdata,
  output axis_pkg::overrun_cnt_t overrun_count
);

  import ad9361_pkg::*;
  import axis_pkg::*;

  localparam int count_width = (burst_len > 1) ? $clog2(burst_len) : 1;

  sample_t    ch_i [num_channels];
  sample_t    ch_q [num_channels];
  axis_data_t data_packed;

  logic       data_frame;
  logic       frame_delay;
  logic       update;
  logic       merged;
  logic       overrun;
  logic       xfer;

  assign ch_i = '{data_i0, data_i1, data_i2, data_i3};
  assign ch_q = '{data_q0, data_q1, data_q2, data_q3};

  ////////////////////////////////////////
  // group capture
  ////////////////////////////////////////

  // lanes from bit 0 up: q3 i3 q2 i2 q1 i1 q0 i0
  always_ff @(posedge m_axis_clk) begin
    if (group_valid) begin
      for (int c = 0; c < num_channels; c++) begin
        data_packed[(2*(num_channels-1-c))*lane_width +: lane_width] <=
          lane_width'(ch_q[c]);
        data_packed[(2*(num_channels-1-c)+1)*lane_width +: lane_width] <=
          lane_width'(ch_i[c]);
      end
    end
  end

  // frame flag flips once per captured group
  always_ff @(posedge m_axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      data_frame  <= 1'b0;
      frame_delay <= 1'b0;
    end else begin
      frame_delay <= data_frame;
      if (group_valid) begin
        data_frame <= ~data_frame;
      end
    end
  end

  assign update = data_frame ^ frame_delay;
  assign tdata  = data_packed;
  assign xfer   = tvalid & tready;

  ////////////////////////////////////////
  // handshake and overrun
  ////////////////////////////////////////

  // new group lands on a beat that is held this cycle
  assign overrun = group_valid & tvalid & ~tready;

  always_ff @(posedge m_axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      tvalid        <= 1'b0;
      merged        <= 1'b0;
      overrun_count <= '0;
    end else begin
      merged <= overrun;
      // a merged group already rides on the pending beat
      tvalid <= (update & ~merged) | (tvalid & ~tready);
      if (overrun && overrun_count != '1) begin
        overrun_count <= overrun_count + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // burst framing
  ////////////////////////////////////////

  generate
    if (use_tlast) begin : g_tlast
      logic [count_width-1:0] beat_count;
      logic                   end_burst;

      assign end_burst = (beat_count == count_width'(burst_len - 1));

      always_ff @(posedge m_axis_clk or negedge arst_n) begin
        if (!arst_n) begin
          beat_count <= '0;
        end else if (xfer) begin
          beat_count <= end_burst ? '0 : beat_count + 1'b1;
        end
      end

      assign tlast = tvalid & end_burst;
    end else begin : g_no_tlast
      assign tlast = 1'b0;
    end
  endgenerate

  // held beat keeps its data unless a newer group replaces it
  tdata_hold_a: assert property (
    @(posedge m_axis_clk) disable iff (!arst_n)
    (tvalid && !tready && !group_valid) |=> (tvalid && $stable(tdata))
  );

  tlast_needs_tvalid_a: assert property (
    @(posedge m_axis_clk) disable iff (!arst_n)
    tlast |-> tvalid
  );

endmodule

// ==== logic/ad9361_rx_capture.sv ====
// AD9361 receive capture top level
// deinterleaves the four channel sample bus and streams it as 128-bit beats

`timescale 1ns/100ps

module ad9361_rx_capture #(
  parameter int burst_len = 512,
  parameter bit use_tlast = 1
) (
  input  logic                   m_axis_clk,
  input  logic                   arst_n,
  input  logic                   rx_valid,
  input  logic                   rx_frame,
  input  ad9361_pkg::sample_t    rx_i,
  input  ad9361_pkg::sample_t    rx_q,
  input  logic                   tready,
  output logic                   tvalid,
  output logic                   tlast,
  output axis_pkg::axis_data_t   tdata,
  output axis_pkg::overrun_cnt_t overrun_count
);

  import ad9361_pkg::*;

  // held channel group between the two stages
  logic    group_valid;
  sample_t data_i0;
  sample_t data_q0;
  sample_t data_i1;
  sample_t data_q1;
  sample_t data_i2;
  sample_t data_q2;
  sample_t data_i3;
  sample_t data_q3;

  rx_deinterleave deint_i (
    .m_axis_clk  (m_axis_clk),
    .arst_n      (arst_n),
    .rx_valid    (rx_valid),
    .rx_frame    (rx_frame),
    .rx_i        (rx_i),
    .rx_q        (rx_q),
    .group_valid (group_valid),
    .data_i0     (data_i0),
    .data_q0     (data_q0),
    .data_i1     (data_i1),
    .data_q1     (data_q1),
    .data_i2     (data_i2),
    .data_q2     (data_q2),
    .data_i3     (data_i3),
    .data_q3     (data_q3)
  );

  ad9361_dual_axis #(
    .burst_len (burst_len),
    .use_tlast (use_tlast)
  ) pack_i (
    .m_axis_clk    (m_axis_clk),
    .arst_n        (arst_n),
    .group_valid   (group_valid),
    .data_i0       (data_i0),
    .data_q0       (data_q0),
    .data_i1       (data_i1),
    .data_q1       (data_q1),
    .data_i2       (data_i2),
    .data_q2       (data_q2),
    .data_i3       (data_i3),
    .data_q3       (data_q3),
    .tready        (tready),
    .tvalid        (tvalid),
    .tlast         (tlast),
    .tdata         (tdata),
    .overrun_count (overrun_count)
  );

endmodule

// ==== sim/tb_ad9361_rx_capture.sv ====
// testbench for the AD9361 receive capture top level
// random channel groups in, packed AXI-stream beats checked against a reference

`timescale 1ns/100ps

module tb_ad9361_rx_capture;

  import ad9361_pkg::*;
  import axis_pkg::*;

  localparam int  clk_period      = 20;
  localparam time drive_dly       = 2;
  localparam int  burst_len       = 8;
  localparam int  n_pack_groups   = 12;
  localparam int  n_burst_groups  = 12;
  localparam int  n_bp_groups     = 10;
  localparam int  total_groups    = n_pack_groups + n_burst_groups + n_bp_groups + 4;
  localparam int  watchdog_cycles = total_groups * 20 + 1000;

  logic         m_axis_clk;
  logic         arst_n;
  logic         rx_valid;
  logic         rx_frame;
  sample_t      rx_i;
  sample_t      rx_q;
  logic         tready;
  logic         tvalid;
  logic         tlast;
  axis_data_t   tdata;
  overrun_cnt_t overrun_count;

  axis_data_t   exp_q [$];
  axis_data_t   exp_beat;
  int           errors;
  int           checks;
  int           xfer_count;
  int           tlast_count;
  int           tests_run;
  int           tests_failed;
  int           test_err_start;

  ad9361_rx_capture #(
    .burst_len (burst_len),
    .use_tlast (1'b1)
  ) dut_i (
    .m_axis_clk    (m_axis_clk),
    .arst_n        (arst_n),
    .rx_valid      (rx_valid),
    .rx_frame      (rx_frame),
    .rx_i          (rx_i),
    .rx_q          (rx_q),
    .tready        (tready),
    .tvalid        (tvalid),
    .tlast         (tlast),
    .tdata         (tdata),
    .overrun_count (overrun_count)
  );

  initial begin
    m_axis_clk = 1'b0;
    forever #(clk_period / 2) m_axis_clk = ~m_axis_clk;
  end

  ////////////////////////////////////////
  // reference and helpers
  ////////////////////////////////////////

  // lanes from bit 0 up: q3 i3 q2 i2 q1 i1 q0 i0, upper nibble zero
  function automatic axis_data_t pack_beat(input sample_t i0, input sample_t q0,
                                           input sample_t i1, input sample_t q1,
                                           input sample_t i2, input sample_t q2,
                                           input sample_t i3, input sample_t q3);
    return {4'h0, i0, 4'h0, q0, 4'h0, i1, 4'h0, q1,
            4'h0, i2, 4'h0, q2, 4'h0, i3, 4'h0, q3};
  endfunction

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("FAIL %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  // next drive point, just after the rising edge
  task automatic step();
    @(posedge m_axis_clk);
    #drive_dly;
  endtask

  task automatic drive_word(input logic valid, input logic frame,
                            input sample_t i, input sample_t q);
    rx_valid = valid;
    rx_frame = frame;
    rx_i     = i;
    rx_q     = q;
    step();
  endtask

  // one group of four words, then four idle cycles
  task automatic send_group(input bit expect_beat);
    sample_t gi [4];
    sample_t gq [4];
    for (int s = 0; s < 4; s++) begin
      gi[s] = sample_t'($urandom_range(0, 4095));
      gq[s] = sample_t'($urandom_range(0, 4095));
    end
    if (expect_beat) begin
      exp_q.push_back(pack_beat(gi[0], gq[0], gi[1], gq[1], gi[2], gq[2], gi[3], gq[3]));
    end
    for (int s = 0; s < 4; s++) begin
      drive_word(1'b1, s == 0, gi[s], gq[s]);
    end
    rx_valid = 1'b0;
    rx_frame = 1'b0;
    repeat (4) step();
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || tvalid) step();
    repeat (4) step();
  endtask

  task automatic start_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_err_start);
    end
  endtask

  ////////////////////////////////////////
  // beat checker
  ////////////////////////////////////////

  // outputs settle well before the falling edge
  always @(negedge m_axis_clk) begin
    if (arst_n) begin
      if (!tvalid) begin
        check(!tlast, "tlast high without tvalid");
      end
      if (tvalid && tready) begin
        checks++;
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("unexpected beat at %0t ns: no group was sent for it", $time);
        end
        if (exp_q.size() != 0) begin
          exp_beat = exp_q.pop_front();
          check(tdata === exp_beat, $sformatf("beat %0d tdata %h, expected %h",
                                             xfer_count, tdata, exp_beat));
        end
        check(tlast === ((xfer_count % burst_len) == burst_len - 1),
              $sformatf("beat %0d tlast %b", xfer_count, tlast));
        if (tlast) begin
          tlast_count++;
        end
        xfer_count++;
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog timeout: the run did not finish in the expected time");
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    axis_data_t   held;
    int           hold;
    int           x0;
    int           t0;
    overrun_cnt_t ov0;

    void'($urandom(89799));
    arst_n   = 1'b0;
    rx_valid = 1'b0;
    rx_frame = 1'b0;
    rx_i     = '0;
    rx_q     = '0;
    tready   = 1'b0;
    repeat (5) @(posedge m_axis_clk);
    #drive_dly;
    arst_n = 1'b1;

    start_test();
    @(negedge m_axis_clk);
    check(tvalid === 1'b0, "tvalid not low after reset");
    check(tlast === 1'b0, "tlast not low after reset");
    check(overrun_count === '0, "overrun_count not zero after reset");
    step();
    end_test("reset");

    start_test();
    tready = 1'b1;
    x0 = xfer_count;
    for (int g = 0; g < n_pack_groups; g++) send_group(1'b1);
    drain();
    check(xfer_count - x0 == n_pack_groups, "packing beat count");
    end_test("packing");

    start_test();
    x0 = xfer_count;
    t0 = tlast_count;
    for (int g = 0; g < n_burst_groups; g++) send_group(1'b1);
    drain();
    check(tlast_count - t0 == xfer_count / burst_len - x0 / burst_len,
          $sformatf("burst tlast count %0d", tlast_count - t0));
    end_test("bursts");

    start_test();
    x0 = xfer_count;
    for (int g = 0; g < n_bp_groups; g++) begin
      tready = 1'b0;
      send_group(1'b1);
      @(negedge m_axis_clk);
      while (!tvalid) @(negedge m_axis_clk);
      held = tdata;
      hold = $urandom_range(1, 8);
      repeat (hold) begin
        @(negedge m_axis_clk);
        check(tvalid && tdata === held,
              $sformatf("held beat changed, tvalid %b tdata %h", tvalid, tdata));
      end
      step();
      tready = 1'b1;
      step();
    end
    drain();
    check(xfer_count - x0 == n_bp_groups, "back-pressure beat count");
    end_test("back-pressure");

    // first group is overwritten, only the second is delivered
    start_test();
    tready = 1'b0;
    x0  = xfer_count;
    ov0 = overrun_count;
    send_group(1'b0);
    @(negedge m_axis_clk);
    while (!tvalid) @(negedge m_axis_clk);
    step();
    send_group(1'b1);
    check(overrun_count == ov0 + 1, $sformatf("overrun_count %0d", overrun_count));
    check(tvalid === 1'b1, "tvalid dropped after overrun");
    tready = 1'b1;
    drain();
    check(xfer_count - x0 == 1, "overrun beat count");
    end_test("overrun");

    start_test();
    x0 = xfer_count;
    // stray word while idle, then a partial group cut by a new marker
    drive_word(1'b1, 1'b0, sample_t'($urandom_range(0, 4095)), sample_t'($urandom_range(0, 4095)));
    drive_word(1'b1, 1'b1, sample_t'($urandom_range(0, 4095)), sample_t'($urandom_range(0, 4095)));
    drive_word(1'b1, 1'b0, sample_t'($urandom_range(0, 4095)), sample_t'($urandom_range(0, 4095)));
    drive_word(1'b1, 1'b0, sample_t'($urandom_range(0, 4095)), sample_t'($urandom_range(0, 4095)));
    send_group(1'b1);
    drain();
    check(xfer_count - x0 == 1, "resync beat count");
    end_test("resync");

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
common/ad9361_pkg.sv
common/axis_pkg.sv
logic/rx_deinterleave.sv
ad9361_dual_axis/ad9361_dual_axis.sv
logic/ad9361_rx_capture.sv
sim/tb_ad9361_rx_capture.sv

// ==== Bender.yml ====
package:
  name: ad9361_rx_capture

sources:
  # packages first
  - common/ad9361_pkg.sv
  - common/axis_pkg.sv
  # design
  - logic/rx_deinterleave.sv
  - ad9361_dual_axis/ad9361_dual_axis.sv
  - logic/ad9361_rx_capture.sv
  # testbench
  - target: test
    files:
      - sim/tb_ad9361_rx_capture.sv
